/* verilog/dcache_pkg.sv */
package dcache_pkg;

   // ********************
   // Geometry
   // ********************
   parameter int ADDR_W         = 32;
   parameter int DATA_W         = 32;
   parameter int WORDS_PER_LINE = 8;
   parameter int WORD_OFF_W     = 3;
   parameter int BYTE_OFF_W     = 2;
   parameter int LINE_ADDR_W    = ADDR_W - WORD_OFF_W - BYTE_OFF_W;
   parameter int NUM_WAYS       = 2;

   typedef logic [WORDS_PER_LINE-1:0][DATA_W-1:0] line_t;

   // Full line address works for any set count
   typedef struct packed {
      logic                   valid;
      logic                   dirty;
      logic [LINE_ADDR_W-1:0] line_addr;
   } tag_entry_t;

   typedef struct packed {
      logic              read;
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [3:0]        byte_en;
   } cpu_req_t;

   // ********************
   // Memory bus
   // ********************
   typedef struct packed {
      logic              arvalid;
      logic [ADDR_W-1:0] araddr;
      logic              rready;
   } axi_rd_req_t;

   typedef struct packed {
      logic              arready;
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
      logic              rlast;
   } axi_rd_rsp_t;

   typedef struct packed {
      logic              awvalid;
      logic [ADDR_W-1:0] awaddr;
      logic              wvalid;
      logic [DATA_W-1:0] wdata;
      logic              wlast;
      logic              bready;
   } axi_wr_req_t;

   typedef struct packed {
      logic awready;
      logic wready;
      logic bvalid;
   } axi_wr_rsp_t;

   typedef enum logic [2:0] {
      IDLE, WB_REQ, WB_WAIT, FILL_REQ, FILL_WAIT, INSTALL
   } miss_state_t;

endpackage

/* verilog/dcache_way_store.sv */
`timescale 1ns/1ps

module dcache_way_store #(
   parameter int  SET_BITS  = 4,
   parameter type PAYLOAD_T = logic [31:0]
) (
   input  logic                clk,
   input  logic                reset,
   input  logic [SET_BITS-1:0] i_set_idx,
   input  logic                i_we,
   input  PAYLOAD_T            i_wdata,
   output PAYLOAD_T            o_rdata
);

   localparam int NUM_SETS = 2 ** SET_BITS;

   PAYLOAD_T entries [NUM_SETS];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < NUM_SETS; s++) begin
            entries[s] <= '0;  // Tag entries come up invalid
         end
      end else if (i_we) begin
         entries[i_set_idx] <= i_wdata;
      end
   end

   // Combinational read of the indexed set
   assign o_rdata = entries[i_set_idx];

endmodule

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl #(
   parameter int SET_BITS = 4
) (
   input  logic                                       clk,
   input  logic                                       reset,
   input  dcache_pkg::cpu_req_t                       i_cpu_req,
   output logic                                       o_stall,
   output logic [dcache_pkg::DATA_W-1:0]              o_rddata,
   output logic [SET_BITS-1:0]                        o_set_idx,
   input  dcache_pkg::tag_entry_t [dcache_pkg::NUM_WAYS-1:0] i_tags,
   input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] i_lines,
   output logic [dcache_pkg::NUM_WAYS-1:0]            o_tag_we,
   output dcache_pkg::tag_entry_t                     o_tag_wdata,
   output logic [dcache_pkg::NUM_WAYS-1:0]            o_line_we,
   output dcache_pkg::line_t                          o_line_wdata,
   output logic                                       o_fill_start,
   output logic                                       o_wb_start,
   output logic [dcache_pkg::LINE_ADDR_W-1:0]         o_bus_line_addr,
   output dcache_pkg::line_t                          o_wb_line,
   input  logic                                       i_fill_done,
   input  dcache_pkg::line_t                          i_fill_line,
   input  logic                                       i_wb_done
);

   localparam int NUM_SETS = 2 ** SET_BITS;

   dcache_pkg::miss_state_t               state;
   logic [dcache_pkg::LINE_ADDR_W-1:0]    req_line_addr;
   logic [dcache_pkg::LINE_ADDR_W-1:0]    miss_line_addr;
   logic [dcache_pkg::WORD_OFF_W-1:0]     word_idx;
   logic [dcache_pkg::NUM_WAYS-1:0]       way_hit;
   logic [NUM_SETS-1:0]                   lru;  // Way to replace next
   logic                                  active;
   logic                                  hit;
   logic                                  hit_way;
   logic                                  accept;
   logic                                  lru_way;
   logic                                  victim;
   logic [dcache_pkg::DATA_W-1:0]         hit_word;
   logic [dcache_pkg::DATA_W-1:0]         merged_word;
   dcache_pkg::line_t                     merged_line;

   assign req_line_addr = i_cpu_req.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::LINE_ADDR_W];
   assign word_idx      = i_cpu_req.addr[dcache_pkg::BYTE_OFF_W +: dcache_pkg::WORD_OFF_W];
   assign active        = i_cpu_req.read | i_cpu_req.write;
   assign o_set_idx     = (state == dcache_pkg::IDLE) ? req_line_addr[SET_BITS-1:0]
                                                      : miss_line_addr[SET_BITS-1:0];

   // ********************
   // Hit path
   // ********************
   always_comb begin
      for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
         way_hit[w] = i_tags[w].valid && (i_tags[w].line_addr == req_line_addr);
      end
   end

   assign hit      = |way_hit;
   assign hit_way  = way_hit[1];
   assign accept   = active && hit && (state == dcache_pkg::IDLE);
   assign hit_word = i_lines[hit_way][word_idx];
   assign o_rddata = hit_word;
   assign o_stall  = (active && !hit) || (state != dcache_pkg::IDLE);
   assign lru_way  = lru[o_set_idx];

   always_comb begin
      merged_word = hit_word;
      for (int b = 0; b < 4; b++) begin
         if (i_cpu_req.byte_en[b]) merged_word[8*b +: 8] = i_cpu_req.wdata[8*b +: 8];
      end
      merged_line = i_lines[hit_way];
      merged_line[word_idx] = merged_word;
   end

   // Install has priority over a write hit
   always_comb begin
      o_tag_we     = '0;
      o_line_we    = '0;
      o_tag_wdata  = '{valid: 1'b1, dirty: 1'b1, line_addr: req_line_addr};
      o_line_wdata = merged_line;
      if (state == dcache_pkg::INSTALL) begin
         o_tag_we[victim]  = 1'b1;
         o_line_we[victim] = 1'b1;
         o_tag_wdata       = '{valid: 1'b1, dirty: 1'b0, line_addr: miss_line_addr};
         o_line_wdata      = i_fill_line;  // Held by the bus master
      end else if (accept && i_cpu_req.write) begin
         o_tag_we  = way_hit;
         o_line_we = way_hit;
      end
   end

   assign o_wb_start      = (state == dcache_pkg::WB_REQ);
   assign o_fill_start    = (state == dcache_pkg::FILL_REQ);
   assign o_bus_line_addr = o_wb_start ? i_tags[victim].line_addr : miss_line_addr;
   assign o_wb_line       = i_lines[victim];

   always_ff @(posedge clk) begin
      if (reset) begin
         lru <= '0;
      end else if (state == dcache_pkg::INSTALL) begin
         lru[o_set_idx] <= ~victim;
      end else if (accept) begin
         lru[o_set_idx] <= ~hit_way;
      end
   end

   // ********************
   // Miss FSM
   // ********************
   always_ff @(posedge clk) begin
      if (state == dcache_pkg::IDLE && active && !hit) begin
         miss_line_addr <= req_line_addr;
         victim         <= lru_way;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= dcache_pkg::IDLE;
      end else begin
         case (state)
            dcache_pkg::IDLE: begin
               if (active && !hit) begin
                  // Dirty victim goes out before the refill
                  if (i_tags[lru_way].valid && i_tags[lru_way].dirty)
                     state <= dcache_pkg::WB_REQ;
                  else
                     state <= dcache_pkg::FILL_REQ;
               end
            end
            dcache_pkg::WB_REQ:    state <= dcache_pkg::WB_WAIT;
            dcache_pkg::WB_WAIT:   if (i_wb_done) state <= dcache_pkg::FILL_REQ;
            dcache_pkg::FILL_REQ:  state <= dcache_pkg::FILL_WAIT;
            dcache_pkg::FILL_WAIT: if (i_fill_done) state <= dcache_pkg::INSTALL;
            dcache_pkg::INSTALL:   state <= dcache_pkg::IDLE;
            default:               state <= dcache_pkg::IDLE;
         endcase
      end
   end

endmodule

/* verilog/dcache_bus_master.sv */
`timescale 1ns/1ps

module dcache_bus_master (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               i_fill_start,
   input  logic                               i_wb_start,
   input  logic [dcache_pkg::LINE_ADDR_W-1:0] i_line_addr,
   input  dcache_pkg::line_t                  i_wb_line,
   output logic                               o_fill_done,
   output dcache_pkg::line_t                  o_fill_line,
   output logic                               o_wb_done,
   output dcache_pkg::axi_rd_req_t            o_rd_req,
   input  dcache_pkg::axi_rd_rsp_t            i_rd_rsp,
   output dcache_pkg::axi_wr_req_t            o_wr_req,
   input  dcache_pkg::axi_wr_rsp_t            i_wr_rsp
);

   localparam int LINE_OFF_W = dcache_pkg::WORD_OFF_W + dcache_pkg::BYTE_OFF_W;

   logic                              arvalid;
   logic [dcache_pkg::ADDR_W-1:0]     araddr;
   logic [dcache_pkg::WORD_OFF_W-1:0] rd_cnt;
   logic                              awvalid;
   logic [dcache_pkg::ADDR_W-1:0]     awaddr;
   logic                              wvalid;
   logic [dcache_pkg::WORD_OFF_W-1:0] wr_cnt;
   logic                              wr_busy;  // Until the b response
   dcache_pkg::line_t                 wb_line;
   logic                              r_beat;
   logic                              w_beat;
   logic                              b_beat;

   assign r_beat = i_rd_rsp.rvalid && o_rd_req.rready;
   assign w_beat = wvalid && i_wr_rsp.wready;
   assign b_beat = wr_busy && i_wr_rsp.bvalid && o_wr_req.bready;

   // ********************
   // Refill burst
   // ********************
   always_ff @(posedge clk) begin
      if (reset) begin
         arvalid     <= 1'b0;
         rd_cnt      <= '0;
         o_fill_done <= 1'b0;
      end else begin
         o_fill_done <= r_beat && i_rd_rsp.rlast;
         if (i_fill_start) arvalid <= 1'b1;
         else if (arvalid && i_rd_rsp.arready) arvalid <= 1'b0;
         if (i_fill_start) rd_cnt <= '0;
         else if (r_beat) rd_cnt <= rd_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_fill_start) araddr <= {i_line_addr, {LINE_OFF_W{1'b0}}};
      if (r_beat) o_fill_line[rd_cnt] <= i_rd_rsp.rdata;
   end

   // ********************
   // Write-back burst
   // ********************
   always_ff @(posedge clk) begin
      if (reset) begin
         awvalid   <= 1'b0;
         wvalid    <= 1'b0;
         wr_cnt    <= '0;
         wr_busy   <= 1'b0;
         o_wb_done <= 1'b0;
      end else begin
         o_wb_done <= b_beat;
         if (i_wb_start) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;  // Data goes along with the address
            wr_cnt  <= '0;
            wr_busy <= 1'b1;
         end else begin
            if (awvalid && i_wr_rsp.awready) awvalid <= 1'b0;
            if (w_beat) begin
               wr_cnt <= wr_cnt + 1'b1;
               if (wr_cnt == '1) wvalid <= 1'b0;
            end
            if (b_beat) wr_busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_wb_start) begin
         awaddr  <= {i_line_addr, {LINE_OFF_W{1'b0}}};
         wb_line <= i_wb_line;
      end
   end

   assign o_rd_req.arvalid = arvalid;
   assign o_rd_req.araddr  = araddr;
   assign o_rd_req.rready  = 1'b1;

   assign o_wr_req.awvalid = awvalid;
   assign o_wr_req.awaddr  = awaddr;
   assign o_wr_req.wvalid  = wvalid;
   assign o_wr_req.wdata   = wb_line[wr_cnt];
   assign o_wr_req.wlast   = wvalid && (wr_cnt == '1);  // Eighth beat
   assign o_wr_req.bready  = 1'b1;

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
   parameter int SET_BITS = 4
) (
   input  logic                         clk,
   input  logic                         reset,
   input  dcache_pkg::cpu_req_t         i_cpu_req,
   output logic                         o_stall,
   output logic [dcache_pkg::DATA_W-1:0] o_rddata,
   output dcache_pkg::axi_rd_req_t      o_rd_req,
   input  dcache_pkg::axi_rd_rsp_t      i_rd_rsp,
   output dcache_pkg::axi_wr_req_t      o_wr_req,
   input  dcache_pkg::axi_wr_rsp_t      i_wr_rsp
);

   logic [SET_BITS-1:0]                           set_idx;
   dcache_pkg::tag_entry_t [dcache_pkg::NUM_WAYS-1:0] tags;
   dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0]  lines;
   logic [dcache_pkg::NUM_WAYS-1:0]               tag_we;
   dcache_pkg::tag_entry_t                        tag_wdata;
   logic [dcache_pkg::NUM_WAYS-1:0]               line_we;
   dcache_pkg::line_t                             line_wdata;
   logic                                          fill_start;
   logic                                          wb_start;
   logic [dcache_pkg::LINE_ADDR_W-1:0]            bus_line_addr;
   dcache_pkg::line_t                             wb_line;
   logic                                          fill_done;
   dcache_pkg::line_t                             fill_line;
   logic                                          wb_done;

   dcache_ctrl #(.SET_BITS(SET_BITS)) ctrl (
      .clk             (clk),
      .reset           (reset),
      .i_cpu_req       (i_cpu_req),
      .o_stall         (o_stall),
      .o_rddata        (o_rddata),
      .o_set_idx       (set_idx),
      .i_tags          (tags),
      .i_lines         (lines),
      .o_tag_we        (tag_we),
      .o_tag_wdata     (tag_wdata),
      .o_line_we       (line_we),
      .o_line_wdata    (line_wdata),
      .o_fill_start    (fill_start),
      .o_wb_start      (wb_start),
      .o_bus_line_addr (bus_line_addr),
      .o_wb_line       (wb_line),
      .i_fill_done     (fill_done),
      .i_fill_line     (fill_line),
      .i_wb_done       (wb_done)
   );

   dcache_bus_master bus_master (
      .clk          (clk),
      .reset        (reset),
      .i_fill_start (fill_start),
      .i_wb_start   (wb_start),
      .i_line_addr  (bus_line_addr),
      .i_wb_line    (wb_line),
      .o_fill_done  (fill_done),
      .o_fill_line  (fill_line),
      .o_wb_done    (wb_done),
      .o_rd_req     (o_rd_req),
      .i_rd_rsp     (i_rd_rsp),
      .o_wr_req     (o_wr_req),
      .i_wr_rsp     (i_wr_rsp)
   );

   // One tag store and one data store per way
   for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : ways
      dcache_way_store #(
         .SET_BITS  (SET_BITS),
         .PAYLOAD_T (dcache_pkg::tag_entry_t)
      ) tag_ways (
         .clk       (clk),
         .reset     (reset),
         .i_set_idx (set_idx),
         .i_we      (tag_we[w]),
         .i_wdata   (tag_wdata),
         .o_rdata   (tags[w])
      );

      dcache_way_store #(
         .SET_BITS  (SET_BITS),
         .PAYLOAD_T (dcache_pkg::line_t)
      ) data_ways (
         .clk       (clk),
         .reset     (reset),
         .i_set_idx (set_idx),
         .i_we      (line_we[w]),
         .i_wdata   (line_wdata),
         .o_rdata   (lines[w])
      );
   end

endmodule

/* testbench/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model (
   input  logic                    clk,
   input  logic                    reset,
   input  dcache_pkg::axi_rd_req_t i_rd_req,
   output dcache_pkg::axi_rd_rsp_t o_rd_rsp,
   input  dcache_pkg::axi_wr_req_t i_wr_req,
   output dcache_pkg::axi_wr_rsp_t o_wr_rsp
);

   logic [31:0] mem [logic [29:0]];  // Only written words are stored
   logic [31:0] rng;
   logic [31:0] rd_addr;
   logic [31:0] aw_addr;
   logic [31:0] wbuf [8];
   int          ar_gap, aw_gap, w_gap, r_gap;
   int          rd_beat, w_cnt;
   bit          rd_busy, aw_got, w_got;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Random gap of 0 to 3 cycles
   function automatic int next_delay();
      rng = xorshift(rng);
      return int'(rng[1:0]);
   endfunction

   // Untouched words hold their own word address
   function automatic logic [31:0] read_word(input logic [31:0] addr);
      if (mem.exists(addr[31:2])) return mem[addr[31:2]];
      return {2'b00, addr[31:2]};
   endfunction

   always @(posedge clk) begin
      if (reset) begin
         rng      = 32'd43836;
         ar_gap   = 0;
         aw_gap   = 0;
         w_gap    = 0;
         r_gap    = 0;
         rd_beat  = 0;
         w_cnt    = 0;
         rd_busy  = 0;
         aw_got   = 0;
         w_got    = 0;
         o_rd_rsp <= '0;
         o_wr_rsp <= '0;
      end else begin
         // ********************
         // Read channel
         // ********************
         if (i_rd_req.arvalid && o_rd_rsp.arready) begin
            rd_addr = i_rd_req.araddr;
            rd_busy = 1;
            rd_beat = 0;
            r_gap   = next_delay();
            ar_gap  = next_delay();
         end else if (ar_gap > 0 && i_rd_req.arvalid) begin
            ar_gap--;  // Gap holds off the next address
         end
         if (o_rd_rsp.rvalid && i_rd_req.rready) begin
            if (rd_beat == 7) rd_busy = 0;
            else begin
               rd_beat++;
               r_gap = next_delay();
            end
         end else if (r_gap > 0) begin
            r_gap--;
         end
         o_rd_rsp.arready <= (ar_gap == 0);
         o_rd_rsp.rvalid  <= rd_busy && (r_gap == 0);
         o_rd_rsp.rdata   <= read_word(rd_addr + 32'(rd_beat * 4));
         o_rd_rsp.rlast   <= (rd_beat == 7);

         // ********************
         // Write channel
         // ********************
         if (o_wr_rsp.bvalid && i_wr_req.bready) o_wr_rsp.bvalid <= 1'b0;
         if (i_wr_req.awvalid && o_wr_rsp.awready) begin
            aw_addr = i_wr_req.awaddr;
            aw_got  = 1;
            aw_gap  = next_delay();
         end else if (aw_gap > 0 && i_wr_req.awvalid) begin
            aw_gap--;
         end
         if (i_wr_req.wvalid && o_wr_rsp.wready) begin
            wbuf[w_cnt] = i_wr_req.wdata;
            w_cnt++;
            if (i_wr_req.wlast) w_got = 1;
            w_gap = next_delay();
         end else if (w_gap > 0) begin
            w_gap--;
         end
         if (aw_got && w_got) begin
            for (int i = 0; i < 8; i++) begin
               mem[aw_addr[31:2] + 30'(i)] = wbuf[i];
            end
            aw_got = 0;
            w_got  = 0;
            w_cnt  = 0;
            o_wr_rsp.bvalid <= 1'b1;
         end
         o_wr_rsp.awready <= (aw_gap == 0);
         o_wr_rsp.wready  <= (w_gap == 0);
      end
   end

endmodule

/* testbench/dcache_sva.sv */
`timescale 1ns/1ps

module dcache_sva (
   input logic                    clk,
   input logic                    reset,
   input dcache_pkg::axi_rd_req_t i_rd_req,
   input dcache_pkg::axi_rd_rsp_t i_rd_rsp,
   input dcache_pkg::axi_wr_req_t i_wr_req,
   input dcache_pkg::axi_wr_rsp_t i_wr_rsp,
   input logic                    i_stall,
   input dcache_pkg::miss_state_t i_state
);

   logic [2:0] w_beats;  // Accepted write beats in the burst

   always_ff @(posedge clk) begin
      if (reset) w_beats <= '0;
      else if (i_wr_req.wvalid && i_wr_rsp.wready) w_beats <= w_beats + 1'b1;
   end

   ar_hold: assert property (@(posedge clk) disable iff (reset)
      i_rd_req.arvalid && !i_rd_rsp.arready |=> i_rd_req.arvalid)
      else $error("arvalid dropped before arready");

   aw_hold: assert property (@(posedge clk) disable iff (reset)
      i_wr_req.awvalid && !i_wr_rsp.awready |=> i_wr_req.awvalid)
      else $error("awvalid dropped before awready");

   w_hold: assert property (@(posedge clk) disable iff (reset)
      i_wr_req.wvalid && !i_wr_rsp.wready |=> i_wr_req.wvalid)
      else $error("wvalid dropped before wready");

   wlast_pos: assert property (@(posedge clk) disable iff (reset)
      i_wr_req.wvalid && i_wr_req.wlast |-> w_beats == 3'd7)
      else $error("wlast seen off the eighth beat");

   stall_busy: assert property (@(posedge clk) disable iff (reset)
      i_state != dcache_pkg::IDLE |-> i_stall)
      else $error("stall low while a miss is in flight");

endmodule

// State comes from the controller inside the top level
bind dcache_top dcache_sva sva (
   .clk      (clk),
   .reset    (reset),
   .i_rd_req (o_rd_req),
   .i_rd_rsp (i_rd_rsp),
   .i_wr_req (o_wr_req),
   .i_wr_rsp (i_wr_rsp),
   .i_stall  (o_stall),
   .i_state  (ctrl.state)
);

/* testbench/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

   localparam int TIMEOUT = 200;

   logic                    clk;
   logic                    reset;
   dcache_pkg::cpu_req_t    cpu_req;
   logic                    stall;
   logic [31:0]             rddata;
   dcache_pkg::axi_rd_req_t rd_req;
   dcache_pkg::axi_rd_rsp_t rd_rsp;
   dcache_pkg::axi_wr_req_t wr_req;
   dcache_pkg::axi_wr_rsp_t wr_rsp;
   int                      rd_bursts;
   int                      wr_bursts;
   int                      errors;

   dcache_top #(.SET_BITS(4)) UUT (
      .clk       (clk),
      .reset     (reset),
      .i_cpu_req (cpu_req),
      .o_stall   (stall),
      .o_rddata  (rddata),
      .o_rd_req  (rd_req),
      .i_rd_rsp  (rd_rsp),
      .o_wr_req  (wr_req),
      .i_wr_rsp  (wr_rsp)
   );

   axi_mem_model mem (
      .clk      (clk),
      .reset    (reset),
      .i_rd_req (rd_req),
      .o_rd_rsp (rd_rsp),
      .i_wr_req (wr_req),
      .o_wr_rsp (wr_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Burst counts from address handshakes
   always @(posedge clk) begin
      if (reset) begin
         rd_bursts <= 0;
         wr_bursts <= 0;
      end else begin
         if (rd_req.arvalid && rd_rsp.arready) rd_bursts <= rd_bursts + 1;
         if (wr_req.awvalid && wr_rsp.awready) wr_bursts <= wr_bursts + 1;
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
   endtask

   // Drive one request and hold it until stall falls
   task automatic run_op(input bit is_write, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] be,
                         input logic [31:0] exp, input int exp_rd, input int exp_wr);
      int          start_rd;
      int          start_wr;
      int          cycles;
      bit          done;
      logic [31:0] got;
      @(negedge clk);
      start_rd = rd_bursts;
      start_wr = wr_bursts;
      @(posedge clk);
      cpu_req.read    <= !is_write;
      cpu_req.write   <= is_write;
      cpu_req.addr    <= addr;
      cpu_req.wdata   <= wdata;
      cpu_req.byte_en <= be;
      done   = 0;
      cycles = 0;
      got    = '0;
      while (!done) begin
         @(negedge clk);
         if (!stall) begin
            got  = rddata;
            done = 1;
         end else begin
            cycles++;
            assert (cycles < TIMEOUT) else begin
               $display("Timeout waiting for stall to fall at address %h", addr);
               $display("*** TEST FAILED ***");
               $fatal(1);
            end
         end
      end
      if (!is_write) check_value("o_rddata", got, exp);
      check_value("read bursts", 32'(rd_bursts - start_rd), 32'(exp_rd));
      check_value("write bursts", 32'(wr_bursts - start_wr), 32'(exp_wr));
      @(posedge clk);  // Completion edge
      cpu_req <= '0;
   endtask

   initial begin
      int          fd;
      int          count;
      int          n_ops;
      string       text;
      string       op;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  be;
      logic [31:0] exp;
      int          exp_rd;
      int          exp_wr;
      errors  = 0;
      n_ops   = 0;
      reset   = 1'b1;
      cpu_req = '0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      fd = $fopen("testbench/dcache_vectors.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the vector file");
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
      while (!$feof(fd)) begin
         count = $fgets(text, fd);
         if (count > 0 && text.substr(0, 0) != "#") begin
            count = $sscanf(text, "%s %h %h %h %h %d %d",
                            op, addr, wdata, be, exp, exp_rd, exp_wr);
            if (count == 7) begin
               run_op(op == "W", addr, wdata, be, exp, exp_rd, exp_wr);
               n_ops++;
            end
         end
      end
      $fclose(fd);
      if (n_ops == 0) errors++;  // Empty vector file

      repeat (2) @(posedge clk);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         $display("No vectors were run");
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
   end

endmodule

/* dcache_top.f */
verilog/dcache_pkg.sv
verilog/dcache_way_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_bus_master.sv
verilog/dcache_top.sv
testbench/axi_mem_model.sv
testbench/dcache_sva.sv
testbench/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f dcache_top.f \
   --top-module tb_dcache \
   -o sim_dcache
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/sim_dcache
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi
exit 0

/* testbench/dcache_vectors.txt */
# op addr wdata byte_en exp_rddata rd_bursts wr_bursts (hex, counts decimal)
# exp_rddata is checked for reads only; memory words start at their word address
R 00000004 00000000 0 00000001 1 0
R 00000004 00000000 0 00000001 0 0
W 00000008 aabbccdd 3 00000000 0 0
R 00000008 00000000 0 0000ccdd 0 0
R 00000200 00000000 0 00000080 1 0
R 00000404 00000000 0 00000101 1 1
R 00000604 00000000 0 00000181 1 0
R 00000008 00000000 0 0000ccdd 1 0
W 00000a10 11223344 c 00000000 1 0
R 00000a10 00000000 0 11220284 0 0
W 00000020 deadbeef f 00000000 1 0
R 00000020 00000000 0 deadbeef 0 0
R 00000c00 00000000 0 00000300 1 0
R 00000e00 00000000 0 00000380 1 1
R 00000a10 00000000 0 11220284 1 0
